// File: list.f
verilog/tlbArrayPkg.sv
verilog/bistSeqPkg.sv
verilog/bistSequencer.sv
verilog/bistPatternGen.sv
verilog/bistResultCheck.sv
verilog/tlbBistTop.sv
tests/tlbArrayModel.sv
tests/tlbBistTb.sv

// File: Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing -j 0 -f list.f --top-module tlbBistTb -o simv
	@out="$$(./obj_dir/simv)"; echo "$$out"; echo "$$out" | grep -qx "TEST RESULT: PASS"

lint:
	verilator --lint-only -Wall --timing -f list.f --top-module tlbBistTb

clean:
	rm -rf obj_dir

// File: tests/tlbBistTb.sv
// tlb bist testbench with fault table, random stalls, request checks and timeout
`timescale 1ns/1ps

module tlbBistTb;

  import tlbArrayPkg::*;
  import bistSeqPkg::*;

  localparam logic [2:0] kNone = 3'd0;
  localparam logic [2:0] kDataFlip = 3'd1;
  localparam logic [2:0] kTagFlip = 3'd2;
  localparam logic [2:0] kForceMiss = 3'd3;
  localparam logic [2:0] kWrongIdx = 3'd4;
  localparam int numRows = 8;
  // 4 backgrounds x 3 sweeps x 64 entries
  localparam int reqsPerRun = 768;

  // chance of low test mode per cycle is stall/(stall+1)
  // expected errors in tag, data, ctrl order
  typedef struct packed
  {
    logic [2:0] kind;
    addrT       entry;
    logic [1:0] stall;
    errT        expErr;
  } rowT;

  localparam rowT rows [numRows] = '{
    '{kNone, 6'd0, 2'd0, 3'b000},
    '{kDataFlip, 6'd5, 2'd0, 3'b010},
    '{kTagFlip, 6'd17, 2'd0, 3'b101},
    '{kForceMiss, 6'd42, 2'd0, 3'b001},
    '{kWrongIdx, 6'd63, 2'd0, 3'b001},
    '{kNone, 6'd0, 2'd1, 3'b000},
    '{kTagFlip, 6'd9, 2'd3, 3'b101},
    '{kWrongIdx, 6'd30, 2'd1, 3'b001}
  };

  // background order of the test algorithm
  localparam bgT bgOrder [4] = '{2'b00, 2'b11, 2'b01, 2'b10};

  logic BIST_Osc = 1'b0;
  logic resetL2;
  logic testMode_i;
  logic tagComp, dataComp, utlbMiss;
  addrT utlbIndex;
  logic wrEn, rdEn, lookupEn, dt;
  addrT addr;
  bgT data;
  epnT epnEa;
  tidT tid;
  dSizeT dSize;
  logic tagErr, dataErr, ctrlErr, done;
  logic [2:0] faultKind;
  addrT faultEntry;
  int reqCount;
  int reqIdx;
  int cycles = 0;
  int cycleLimit;
  logic [31:0] rngState = 32'd51;

  always #4 BIST_Osc = ~BIST_Osc;

  tlbBistTop dut_i
  (
    .BIST_Osc (BIST_Osc), .resetL2 (resetL2), .testMode_i (testMode_i),
    .tagComp_i (tagComp), .dataComp_i (dataComp), .utlbMiss_i (utlbMiss),
    .utlbIndex_i (utlbIndex), .bistWrEn_o (wrEn), .bistRdEn_o (rdEn),
    .bistLookupEn_o (lookupEn), .bistAddr_o (addr), .bistData_o (data),
    .bistEpnEa_o (epnEa), .bistTid_o (tid), .bistDSize_o (dSize), .bistDt_o (dt),
    .tagErr_o (tagErr), .dataErr_o (dataErr), .ctrlErr_o (ctrlErr), .bistDone_o (done)
  );

  tlbArrayModel tlbModel
  (
    .BIST_Osc (BIST_Osc), .resetL2 (resetL2), .wrEn_i (wrEn), .rdEn_i (rdEn),
    .lookupEn_i (lookupEn), .addr_i (addr), .data_i (data), .epnEa_i (epnEa),
    .tid_i (tid), .dSize_i (dSize), .dt_i (dt), .faultKind_i (faultKind),
    .faultEntry_i (faultEntry), .tagComp_o (tagComp), .dataComp_o (dataComp),
    .utlbMiss_o (utlbMiss), .utlbIndex_o (utlbIndex), .reqCount_o (reqCount)
  );

  // ********************
  // failure and compares
  // ********************

  task automatic abortRun();
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic errCompare(string name, errT got, errT exp);
    if (got !== exp)
    begin
      $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
      abortRun();
    end
  endtask

  task automatic bitCompare(string name, logic got, logic exp);
    if (got !== exp)
    begin
      $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
      abortRun();
    end
  endtask

  task automatic addrCompare(string name, addrT got, addrT exp);
    if (got !== exp)
    begin
      $display("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, exp);
      abortRun();
    end
  endtask

  task automatic bgCompare(string name, bgT got, bgT exp);
    if (got !== exp)
    begin
      $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
      abortRun();
    end
  endtask

  task automatic epnCompare(string name, epnT got, epnT exp);
    if (got !== exp)
    begin
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
      abortRun();
    end
  endtask

  task automatic tidCompare(string name, tidT got, tidT exp);
    if (got !== exp)
    begin
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
      abortRun();
    end
  endtask

  task automatic sizeCompare(string name, dSizeT got, dSizeT exp);
    if (got !== exp)
    begin
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
      abortRun();
    end
  endtask

  task automatic countCompare(string name, int got, int exp);
    if (got != exp)
    begin
      $display("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, exp);
      abortRun();
    end
  endtask

  // ********************
  // stimulus helpers
  // ********************

  function automatic logic [31:0] nextRand();
    rngState ^= rngState << 13;
    rngState ^= rngState >> 17;
    rngState ^= rngState << 5;
    return rngState;
  endfunction

  function automatic logic pickMode(logic [1:0] stall);
    return (nextRand() % (32'(stall) + 32'd1)) == 32'd0;
  endfunction

  // request n of a run belongs to iteration n/192, sweep (n/64)%3 and entry n%64
  task automatic inspectRequest();
    int sweep;
    bgT bg;
    addrT a;
    logic [7:0] attr;
    if (reqIdx >= reqsPerRun)
    begin
      $display("more than %0d requests reached the array in one run", reqsPerRun);
      abortRun();
    end
    sweep = (reqIdx / numEntries) % 3;
    bg = bgOrder[reqIdx / (3 * numEntries)];
    a = addrT'(reqIdx % numEntries);
    attr = {4{bg}};
    bitCompare("bistWrEn_o", wrEn, sweep == 0);
    bitCompare("bistRdEn_o", rdEn, sweep == 1);
    bitCompare("bistLookupEn_o", lookupEn, sweep == 2);
    addrCompare("bistAddr_o", addr, a);
    bgCompare("bistData_o", data, bg);
    tidCompare("bistTid_o", tid, {4{bg}});
    sizeCompare("bistDSize_o", dSize, attr[7:1]);
    bitCompare("bistDt_o", dt, attr[0]);
    epnCompare("bistEpnEa_o", epnEa, {{8{bg}}, a});
    reqIdx++;
  endtask

  // outputs settle after the rising edge
  always @(negedge BIST_Osc)
  begin
    if (wrEn || rdEn || lookupEn)
    begin
      inspectRequest();
    end
  end

  always @(posedge BIST_Osc)
  begin
    cycles++;
    if (cycles > cycleLimit)
    begin
      $display("timeout, the run took more than %0d cycles", cycleLimit);
      abortRun();
    end
  end

  task automatic runRow(rowT row);
    @(negedge BIST_Osc);
    resetL2 = 1'b0;
    testMode_i = 1'b0;
    faultKind = row.kind;
    faultEntry = row.entry;
    reqIdx = 0;
    repeat (5) @(negedge BIST_Osc);
    bitCompare("bistWrEn_o", wrEn, 1'b0);
    bitCompare("bistRdEn_o", rdEn, 1'b0);
    bitCompare("bistLookupEn_o", lookupEn, 1'b0);
    errCompare("{tagErr_o,dataErr_o,ctrlErr_o}", errT'({tagErr, dataErr, ctrlErr}), 3'b000);
    bitCompare("bistDone_o", done, 1'b0);
    resetL2 = 1'b1;
    do
    begin
      testMode_i = pickMode(row.stall);
      @(negedge BIST_Osc);
    end
    while (!done);
    testMode_i = 1'b0;
    errCompare("{tagErr_o,dataErr_o,ctrlErr_o}", errT'({tagErr, dataErr, ctrlErr}),
      row.expErr);
    countCompare("model reqCount_o", reqCount, reqsPerRun);
  endtask

  initial
  begin
    int maxStall;
    resetL2 = 1'b0;
    testMode_i = 1'b0;
    faultKind = kNone;
    faultEntry = '0;
    reqIdx = 0;
    maxStall = 0;
    for (int r = 0; r < numRows; r++)
    begin
      if (int'(rows[r].stall) > maxStall)
      begin
        maxStall = int'(rows[r].stall);
      end
    end
    cycleLimit = numRows * (4 * 3 * numEntries * (1 + maxStall) + 20);
    for (int r = 0; r < numRows; r++)
    begin
      runRow(rows[r]);
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: tests/tlbArrayModel.sv
// behavioral 64-entry tlb array with read compare, lookup, fault injection and request count
`timescale 1ns/1ps

module tlbArrayModel
(
  input  logic               BIST_Osc,
  input  logic               resetL2,
  input  logic               wrEn_i,
  input  logic               rdEn_i,
  input  logic               lookupEn_i,
  input  tlbArrayPkg::addrT  addr_i,
  input  tlbArrayPkg::bgT    data_i,
  input  tlbArrayPkg::epnT   epnEa_i,
  input  tlbArrayPkg::tidT   tid_i,
  input  tlbArrayPkg::dSizeT dSize_i,
  input  logic               dt_i,
  input  logic [2:0]         faultKind_i,
  input  tlbArrayPkg::addrT  faultEntry_i,
  output logic               tagComp_o,
  output logic               dataComp_o,
  output logic               utlbMiss_o,
  output tlbArrayPkg::addrT  utlbIndex_o,
  output int                 reqCount_o
);

  import tlbArrayPkg::*;

  // fault kinds numbered as in the testbench table
  localparam logic [2:0] kDataFlip = 3'd1;
  localparam logic [2:0] kTagFlip = 3'd2;
  localparam logic [2:0] kForceMiss = 3'd3;
  localparam logic [2:0] kWrongIdx = 3'd4;

  epnT   epnMem [numEntries];
  tidT   tidMem [numEntries];
  dSizeT sizeMem [numEntries];
  logic  dtMem [numEntries];
  bgT    dataMem [numEntries];
  logic [numEntries-1:0] valid;
  logic  hit;
  addrT  hitIdx;
  logic  atFault;

  assign atFault = (addr_i == faultEntry_i);

  // ********************
  // cam search on epn and tid
  // ********************

  always_comb
  begin
    hit = 1'b0;
    hitIdx = '0;
    for (int i = 0; i < numEntries; i++)
    begin
      if (valid[i] && epnMem[i] == epnEa_i && tidMem[i] == tid_i)
      begin
        hit = 1'b1;
        hitIdx = addrT'(i);
      end
    end
  end

  // ********************
  // write and response
  // ********************

  always_ff @(posedge BIST_Osc)
  begin
    if (!resetL2)
    begin
      valid <= '0;
      tagComp_o <= 1'b1;
      dataComp_o <= 1'b1;
      utlbMiss_o <= 1'b0;
      utlbIndex_o <= '0;
      reqCount_o <= 0;
    end
    else
    begin
      if (wrEn_i || rdEn_i || lookupEn_i)
      begin
        reqCount_o <= reqCount_o + 1;
      end
      if (wrEn_i)
      begin
        // stuck cells flip on the way in
        if (atFault && faultKind_i == kTagFlip)
        begin
          epnMem[addr_i] <= epnEa_i ^ {1'b1, {(epnWidth-1){1'b0}}};
        end
        else
        begin
          epnMem[addr_i] <= epnEa_i;
        end
        if (atFault && faultKind_i == kDataFlip)
        begin
          dataMem[addr_i] <= data_i ^ bgT'(1);
        end
        else
        begin
          dataMem[addr_i] <= data_i;
        end
        tidMem[addr_i] <= tid_i;
        sizeMem[addr_i] <= dSize_i;
        dtMem[addr_i] <= dt_i;
        // without invalidate every write leaves the entry valid
        valid[addr_i] <= 1'b1;
      end
      // read compare against the request fields
      tagComp_o <= (epnMem[addr_i] == epnEa_i) && (tidMem[addr_i] == tid_i)
        && (sizeMem[addr_i] == dSize_i) && (dtMem[addr_i] == dt_i);
      dataComp_o <= (dataMem[addr_i] == data_i);
      utlbMiss_o <= !hit || (lookupEn_i && atFault && faultKind_i == kForceMiss);
      if (lookupEn_i && atFault && faultKind_i == kWrongIdx)
      begin
        utlbIndex_o <= hitIdx ^ addrT'(1);
      end
      else
      begin
        utlbIndex_o <= hitIdx;
      end
    end
  end

endmodule

// File: verilog/tlbBistTop.sv
// tlb bist top with sequencer, pattern and checker stages
`timescale 1ns/1ps

module tlbBistTop
(
  input  logic               BIST_Osc,
  input  logic               resetL2,
  input  logic               testMode_i,
  input  logic               tagComp_i,
  input  logic               dataComp_i,
  input  logic               utlbMiss_i,
  input  tlbArrayPkg::addrT  utlbIndex_i,
  output logic               bistWrEn_o,
  output logic               bistRdEn_o,
  output logic               bistLookupEn_o,
  output tlbArrayPkg::addrT  bistAddr_o,
  output tlbArrayPkg::bgT    bistData_o,
  output tlbArrayPkg::epnT   bistEpnEa_o,
  output tlbArrayPkg::tidT   bistTid_o,
  output tlbArrayPkg::dSizeT bistDSize_o,
  output logic               bistDt_o,
  output logic               tagErr_o,
  output logic               dataErr_o,
  output logic               ctrlErr_o,
  output logic               bistDone_o
);

  import tlbArrayPkg::*;
  import bistSeqPkg::*;

  // sequencer to pattern stage
  opE   seqOp;
  addrT seqAddr;
  bgT   seqBg;
  logic seqLast;
  // pattern stage to checker
  opE   reqOp;
  logic reqLast;
  errT  err;

  bistSequencer seq_i
  (
    .BIST_Osc   (BIST_Osc),
    .resetL2    (resetL2),
    .testMode_i (testMode_i),
    .op_o       (seqOp),
    .addr_o     (seqAddr),
    .bg_o       (seqBg),
    .lastOp_o   (seqLast)
  );

  bistPatternGen pat_i
  (
    .BIST_Osc   (BIST_Osc),
    .resetL2    (resetL2),
    .op_i       (seqOp),
    .addr_i     (seqAddr),
    .bg_i       (seqBg),
    .lastOp_i   (seqLast),
    .wrEn_o     (bistWrEn_o),
    .rdEn_o     (bistRdEn_o),
    .lookupEn_o (bistLookupEn_o),
    .addr_o     (bistAddr_o),
    .data_o     (bistData_o),
    .epnEa_o    (bistEpnEa_o),
    .tid_o      (bistTid_o),
    .dSize_o    (bistDSize_o),
    .dt_o       (bistDt_o),
    .op_o       (reqOp),
    .lastOp_o   (reqLast)
  );

  // checker takes the address as driven to the array
  bistResultCheck chk_i
  (
    .BIST_Osc    (BIST_Osc),
    .resetL2     (resetL2),
    .op_i        (reqOp),
    .addr_i      (bistAddr_o),
    .lastOp_i    (reqLast),
    .tagComp_i   (tagComp_i),
    .dataComp_i  (dataComp_i),
    .utlbMiss_i  (utlbMiss_i),
    .utlbIndex_i (utlbIndex_i),
    .err_o       (err),
    .done_o      (bistDone_o)
  );

  assign tagErr_o = err[errTagBit];
  assign dataErr_o = err[errDataBit];
  assign ctrlErr_o = err[errCtrlBit];

endmodule

// File: verilog/bistResultCheck.sv
// response alignment, sticky error capture and done flag
`timescale 1ns/1ps

module bistResultCheck
(
  input  logic              BIST_Osc,
  input  logic              resetL2,
  input  bistSeqPkg::opE    op_i,
  input  tlbArrayPkg::addrT addr_i,
  input  logic              lastOp_i,
  input  logic              tagComp_i,
  input  logic              dataComp_i,
  input  logic              utlbMiss_i,
  input  tlbArrayPkg::addrT utlbIndex_i,
  output bistSeqPkg::errT   err_o,
  output logic              done_o
);

  import tlbArrayPkg::*;
  import bistSeqPkg::*;

  // request as seen in the response cycle
  opE   opQ;
  addrT addrQ;
  logic lastQ;
  // errors found in this response
  errT  errNow;

  // ********************
  // alignment
  // ********************

  // array answers one cycle after the request
  always_ff @(posedge BIST_Osc)
  begin
    if (!resetL2)
    begin
      opQ <= opNone;
      lastQ <= 1'b0;
    end
    else
    begin
      opQ <= op_i;
      lastQ <= lastOp_i;
    end
  end

  // expected lookup index
  always_ff @(posedge BIST_Osc)
  begin
    addrQ <= addr_i;
  end

  // ********************
  // compare
  // ********************

  always_comb
  begin
    errNow = '0;
    // read compares the stored tag and data against the request
    errNow[errTagBit] = (opQ == opRead) && !tagComp_i;
    errNow[errDataBit] = (opQ == opRead) && !dataComp_i;
    // every tag is unique, so a lookup must hit its own entry
    errNow[errCtrlBit] = (opQ == opLookup) && (utlbMiss_i || (utlbIndex_i != addrQ));
  end

  // sticky until reset
  always_ff @(posedge BIST_Osc)
  begin
    if (!resetL2)
    begin
      err_o <= '0;
      done_o <= 1'b0;
    end
    else
    begin
      err_o <= err_o | errNow;
      // last lookup checked in the same cycle
      if (lastQ)
      begin
        done_o <= 1'b1;
      end
    end
  end

endmodule

// File: verilog/bistPatternGen.sv
// request register with strobe decode and background expansion
`timescale 1ns/1ps

module bistPatternGen
(
  input  logic               BIST_Osc,
  input  logic               resetL2,
  input  bistSeqPkg::opE     op_i,
  input  tlbArrayPkg::addrT  addr_i,
  input  tlbArrayPkg::bgT    bg_i,
  input  logic               lastOp_i,
  output logic               wrEn_o,
  output logic               rdEn_o,
  output logic               lookupEn_o,
  output tlbArrayPkg::addrT  addr_o,
  output tlbArrayPkg::bgT    data_o,
  output tlbArrayPkg::epnT   epnEa_o,
  output tlbArrayPkg::tidT   tid_o,
  output tlbArrayPkg::dSizeT dSize_o,
  output logic               dt_o,
  output bistSeqPkg::opE     op_o,
  output logic               lastOp_o
);

  import tlbArrayPkg::*;
  import bistSeqPkg::*;

  // background copies per field
  localparam int tidReps = $bits(tidT) / $bits(bgT);
  localparam int attrReps = ($bits(dSizeT) + 1) / $bits(bgT);
  // epn keeps the entry address in its low bits
  localparam int epnReps = ($bits(epnT) - $bits(addrT)) / $bits(bgT);

  logic reqValid;

  assign reqValid = (op_i != opNone);

  // strobes and alignment tags
  always_ff @(posedge BIST_Osc)
  begin
    if (!resetL2)
    begin
      wrEn_o <= 1'b0;
      rdEn_o <= 1'b0;
      lookupEn_o <= 1'b0;
      op_o <= opNone;
      lastOp_o <= 1'b0;
    end
    else
    begin
      // a stall arrives as opNone and gives a bubble
      wrEn_o <= (op_i == opWrite);
      rdEn_o <= (op_i == opRead);
      lookupEn_o <= (op_i == opLookup);
      op_o <= op_i;
      lastOp_o <= lastOp_i;
    end
  end

  // ********************
  // payload expansion
  // ********************

  always_ff @(posedge BIST_Osc)
  begin
    // bus holds its last value through bubbles
    if (reqValid)
    begin
      addr_o <= addr_i;
      data_o <= bg_i;
      tid_o <= {tidReps{bg_i}};
      {dSize_o, dt_o} <= {attrReps{bg_i}};
      epnEa_o <= {{epnReps{bg_i}}, addr_i};
    end
  end

endmodule

// File: verilog/bistSequencer.sv
// bist sequencer fsm with phase, iteration and address counters
`timescale 1ns/1ps

module bistSequencer
(
  input  logic               BIST_Osc,
  input  logic               resetL2,
  input  logic               testMode_i,
  output bistSeqPkg::opE     op_o,
  output tlbArrayPkg::addrT  addr_o,
  output tlbArrayPkg::bgT    bg_o,
  output logic               lastOp_o
);

  import tlbArrayPkg::*;
  import bistSeqPkg::*;

  phaseE phase;
  addrT  addr;
  iterT  iter;
  logic  issue;
  logic  lastAddr;
  logic  lastIter;

  // an op goes out every cycle of an active sweep unless test mode drops
  assign issue = testMode_i && (phase == phWrite || phase == phRead || phase == phLookup);
  assign lastAddr = (addr == addrT'(numEntries - 1));
  assign lastIter = (iter == iterT'(numIters - 1));

  // ********************
  // state update
  // ********************

  always_ff @(posedge BIST_Osc)
  begin
    if (!resetL2)
    begin
      phase <= phIdle;
      addr <= '0;
      iter <= '0;
    end
    // low test mode freezes everything
    else if (testMode_i)
    begin
      case (phase)
        phIdle:
        begin
          phase <= phWrite;
          addr <= '0;
          iter <= '0;
        end
        phWrite:
        begin
          // address wraps to 0 at the end of each sweep
          addr <= addr + 1'b1;
          if (lastAddr)
          begin
            phase <= phRead;
          end
        end
        phRead:
        begin
          addr <= addr + 1'b1;
          if (lastAddr)
          begin
            phase <= phLookup;
          end
        end
        phLookup:
        begin
          addr <= addr + 1'b1;
          if (lastAddr)
          begin
            // next background or finish
            if (lastIter)
            begin
              phase <= phDone;
            end
            else
            begin
              phase <= phWrite;
              iter <= iter + 1'b1;
            end
          end
        end
        // done holds until reset
        default:
        begin
        end
      endcase
    end
  end

  // ********************
  // issued operation
  // ********************

  always_comb
  begin
    op_o = opNone;
    if (issue)
    begin
      case (phase)
        phWrite: op_o = opWrite;
        phRead: op_o = opRead;
        default: op_o = opLookup;
      endcase
    end
  end

  assign addr_o = addr;
  // background of the current iteration
  assign bg_o = bgTable[iter];
  // final lookup of the last background
  assign lastOp_o = issue && (phase == phLookup) && lastAddr && lastIter;

endmodule

// File: verilog/bistSeqPkg.sv
// bist algorithm enums, background table and error vector type
package bistSeqPkg;

  // sequencer phases with one sweep over the array each
  typedef enum logic [2:0] {phIdle, phWrite, phRead, phLookup, phDone} phaseE;

  // request kind travelling down the pipeline
  typedef enum logic [1:0] {opNone, opWrite, opRead, opLookup} opE;

  // ********************
  // backgrounds
  // ********************

  localparam int numIters = 4;
  typedef logic [$clog2(numIters)-1:0] iterT;

  // solid zeros, solid ones, then the two checkerboards
  localparam tlbArrayPkg::bgT bgTable [numIters] = '{2'b00, 2'b11, 2'b01, 2'b10};

  // sticky error vector and its bit positions
  typedef logic [2:0] errT;
  localparam int errTagBit = 2;
  localparam int errDataBit = 1;
  localparam int errCtrlBit = 0;

endpackage

// File: verilog/tlbArrayPkg.sv
// tlb array geometry constants and field types
package tlbArrayPkg;

  // ********************
  // array geometry
  // ********************

  // entries in the unified tlb
  localparam int numEntries = 64;
  // entry index width follows the entry count
  localparam int addrWidth = $clog2(numEntries);

  // tag field widths as seen on the array ports
  localparam int epnWidth = 22;
  localparam int tidWidth = 8;
  localparam int dSizeWidth = 7;

  // data port width and the width of one background
  localparam int bgWidth = 2;

  // ********************
  // field types
  // ********************

  // entry index
  typedef logic [addrWidth-1:0] addrT;
  // effective page number
  typedef logic [epnWidth-1:0] epnT;
  // translation id
  typedef logic [tidWidth-1:0] tidT;
  // page size field
  typedef logic [dSizeWidth-1:0] dSizeT;
  // data background and array data word
  typedef logic [bgWidth-1:0] bgT;

endpackage
